/* tb.f */
source/ctl_pkg.sv
source/settings_pkg.sv
source/cnt_ram.sv
source/ctl_poller.sv
source/silencer_loader.sv
source/sync_loader.sv
source/settings_top.sv
dv/clk_gen.sv
dv/settings_checker.sv
dv/settings_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module settings_tb -f tb.f -o settings_sim
	./obj_dir/settings_sim

clean:
	rm -rf obj_dir

/* dv/settings_tb.sv */
`timescale 1ns/1ps

module settings_tb;
    import ctl_pkg::*;
    import settings_pkg::*;

    localparam int TIMEOUT_CYCLES = 300;
    localparam int NUM_ROWS = 6;

    typedef struct packed {
        bus_word_t      flag_word;
        silencer_word_t rate_intensity;
        silencer_word_t rate_phase;
        silencer_word_t steps_intensity;
        silencer_word_t steps_phase;
        sync_time_t     sync_time;
        logic           set_silencer;
        logic           set_sync;
        logic           fan;
        logic           thermo;
        logic           mod_segment;
        logic           stm_segment;
        bus_word_t      stm_cycle;
    } row_t;

    // Silencer words, sync time, set silencer, set sync, fan, state inputs.
    localparam row_t STIMULUS [NUM_ROWS] = '{
        '{16'h12A5, 16'd300, 16'd512, 16'd20, 16'd80, 64'h0,
          1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 16'd0},
        '{16'h0001, 16'd1, 16'd2, 16'd3, 16'd4, 64'h0123_4567_89AB_CDEF,
          1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 16'd5},
        '{16'h00FF, 16'd4096, 16'd128, 16'd1000, 16'd2000, 64'hFFFF_0000_AAAA_5555,
          1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 16'd0},
        '{16'h3C3C, 16'd7, 16'd9, 16'd11, 16'd13, 64'h0,
          1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 16'd7},
        '{16'h0000, 16'd0, 16'd0, 16'd0, 16'd0, 64'h0,
          1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 16'hFFFF},
        '{16'hBEEF, 16'd256, 16'd255, 16'd65535, 16'd42, 64'hDEAD_BEEF_0BAD_F00D,
          1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 16'd0}
    };

    logic CLK;
    logic reset;
    logic host_we;
    bus_addr_t host_addr;
    bus_word_t host_din;
    bus_word_t host_dout;
    logic thermo;
    logic mod_segment;
    logic stm_segment;
    bus_word_t stm_cycle;
    silencer_flag_t silencer_flag;
    silencer_word_t update_rate_intensity;
    silencer_word_t update_rate_phase;
    silencer_word_t completion_steps_intensity;
    silencer_word_t completion_steps_phase;
    logic silencer_update;
    sync_time_t ecat_sync_time;
    logic sync_update;
    logic force_fan;

    int seed;
    int update_count = 0;
    silencer_flag_t exp_flag;
    silencer_word_t exp_rate_intensity;
    silencer_word_t exp_rate_phase;
    silencer_word_t exp_steps_intensity;
    silencer_word_t exp_steps_phase;
    sync_time_t exp_sync_time;

    clk_gen u_clk_gen (
        .CLK   (CLK),
        .reset (reset)
    );

    settings_top DUT (.*);

    always @(negedge CLK) begin
        if (!reset && silencer_update) begin
            update_count++;
        end
        if (!reset && sync_update) begin
            update_count++;
        end
    end

    task automatic report_failure(input string text);
        $display("%s", text);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_bus_word(input string name, input bus_word_t got, input bus_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_silencer_word(input string name, input silencer_word_t got,
                                       input silencer_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_silencer_flag(input string name, input silencer_flag_t got,
                                       input silencer_flag_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_sync_time(input string name, input sync_time_t got,
                                   input sync_time_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_outputs();
        check_silencer_flag("silencer_flag", silencer_flag, exp_flag);
        check_silencer_word("update_rate_intensity", update_rate_intensity, exp_rate_intensity);
        check_silencer_word("update_rate_phase", update_rate_phase, exp_rate_phase);
        check_silencer_word("completion_steps_intensity", completion_steps_intensity,
                            exp_steps_intensity);
        check_silencer_word("completion_steps_phase", completion_steps_phase, exp_steps_phase);
        check_sync_time("ecat_sync_time", ecat_sync_time, exp_sync_time);
    endtask

    task automatic host_write(input bus_addr_t addr, input bus_word_t data);
        @(posedge CLK);
        host_we <= 1'b1;
        host_addr <= addr;
        host_din <= data;
        @(posedge CLK);
        host_we <= 1'b0;
    endtask

    // Data is back two edges after the address.
    task automatic host_read(input bus_addr_t addr, output bus_word_t data);
        @(posedge CLK);
        host_addr <= addr;
        repeat (RAM_READ_LATENCY) @(posedge CLK);
        @(negedge CLK);
        data = host_dout;
    endtask

    task automatic poll_word(input bus_addr_t addr, input bus_word_t exp, input string name);
        bus_word_t got;
        int n;
        n = 0;
        do begin
            host_read(addr, got);
            n++;
        end while (got !== exp && n < TIMEOUT_CYCLES / 4);
        check_bus_word(name, got, exp);
    endtask

    task automatic wait_update(input logic want_sync);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < TIMEOUT_CYCLES && !seen; n++) begin
            @(negedge CLK);
            if (want_sync ? sync_update : silencer_update) begin
                seen = 1'b1;
            end else if (want_sync ? silencer_update : sync_update) begin
                report_failure("update strobes came in the wrong order");
            end
        end
        if (!seen) begin
            report_failure(want_sync ? "timeout waiting for sync_update"
                                     : "timeout waiting for silencer_update");
        end
    endtask

    task automatic wait_fan(input logic exp);
        for (int n = 0; n < TIMEOUT_CYCLES && force_fan !== exp; n++) begin
            @(negedge CLK);
        end
        if (force_fan !== exp) begin
            report_failure("force_fan did not follow the flags word in time");
        end
    endtask

    task automatic wait_reset_release();
        for (int n = 0; n < TIMEOUT_CYCLES && reset !== 1'b0; n++) begin
            @(posedge CLK);
        end
        if (reset !== 1'b0) begin
            report_failure("reset was never released");
        end
    endtask

    function automatic bus_word_t pack_state(input row_t row);
        bus_word_t word;
        word = '0;
        word[FPGA_STATE_BIT_THERMO] = row.thermo;
        word[FPGA_STATE_BIT_MOD_SEGMENT] = row.mod_segment;
        word[FPGA_STATE_BIT_STM_SEGMENT] = row.stm_segment;
        word[FPGA_STATE_BIT_STM_CYCLE_ZERO] = (row.stm_cycle == 16'd0);
        return word;
    endfunction

    task automatic apply_row(input row_t row);
        sync_time_t sync_val;
        logic [31:0] rnd_hi;
        logic [31:0] rnd_lo;
        bus_word_t flags;
        int count_before;
        rnd_hi = $random(seed);
        rnd_lo = $random(seed);
        // Table value mixed with random bits.
        sync_val = row.sync_time ^ {rnd_hi, rnd_lo};
        @(posedge CLK);
        thermo <= row.thermo;
        mod_segment <= row.mod_segment;
        stm_segment <= row.stm_segment;
        stm_cycle <= row.stm_cycle;
        host_write(ADDR_SILENCER_BASE, row.flag_word);
        host_write(ADDR_SILENCER_BASE + 8'd1, row.rate_intensity);
        host_write(ADDR_SILENCER_BASE + 8'd2, row.rate_phase);
        host_write(ADDR_SILENCER_BASE + 8'd3, row.steps_intensity);
        host_write(ADDR_SILENCER_BASE + 8'd4, row.steps_phase);
        for (int i = 0; i < SYNC_WORDS; i++) begin
            host_write(ADDR_SYNC_BASE + bus_addr_t'(i),
                       sync_val[i*BUS_DATA_WIDTH +: BUS_DATA_WIDTH]);
        end
        // Unused flag bits carry random filler.
        flags = bus_word_t'($random(seed));
        flags[CTL_FLAG_BIT_SILENCER_SET] = row.set_silencer;
        flags[CTL_FLAG_BIT_SYNC_SET] = row.set_sync;
        flags[CTL_FLAG_BIT_FORCE_FAN] = row.fan;
        count_before = update_count;
        host_write(ADDR_CTL_FLAG, flags);
        if (row.set_silencer) begin
            wait_update(1'b0);
            exp_flag = row.flag_word[SILENCER_FLAG_WIDTH-1:0];
            exp_rate_intensity = row.rate_intensity;
            exp_rate_phase = row.rate_phase;
            exp_steps_intensity = row.steps_intensity;
            exp_steps_phase = row.steps_phase;
        end
        check_outputs();
        if (row.set_sync) begin
            wait_update(1'b1);
            exp_sync_time = sync_val;
        end
        check_outputs();
        // Set bits come back cleared and the rest as written.
        flags[CTL_FLAG_BIT_SILENCER_SET] = 1'b0;
        flags[CTL_FLAG_BIT_SYNC_SET] = 1'b0;
        poll_word(ADDR_CTL_FLAG, flags, "ctl flags");
        wait_fan(row.fan);
        poll_word(ADDR_FPGA_STATE, pack_state(row), "fpga state");
        if (update_count != count_before + int'(row.set_silencer) + int'(row.set_sync)) begin
            report_failure("update strobe count does not match the flags that were set");
        end
    endtask

    initial begin
        host_we = 1'b0;
        host_addr = '0;
        host_din = '0;
        thermo = 1'b0;
        mod_segment = 1'b0;
        stm_segment = 1'b0;
        stm_cycle = '0;
        seed = 98193;
        exp_flag = SILENCER_FLAG_DEFAULT;
        exp_rate_intensity = UPDATE_RATE_DEFAULT;
        exp_rate_phase = UPDATE_RATE_DEFAULT;
        exp_steps_intensity = COMPLETION_STEPS_INTENSITY_DEFAULT;
        exp_steps_phase = COMPLETION_STEPS_PHASE_DEFAULT;
        exp_sync_time = SYNC_TIME_DEFAULT;

        wait_reset_release();
        @(negedge CLK);
        check_outputs();
        if (force_fan !== 1'b0) begin
            report_failure("force_fan is set right after reset");
        end
        poll_word(ADDR_VERSION_NUM_MAJOR, {8'h00, VERSION_NUM_MAJOR}, "version major");
        poll_word(ADDR_VERSION_NUM_MINOR, {8'h00, VERSION_NUM_MINOR}, "version minor");

        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(STIMULUS[r]);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* dv/settings_checker.sv */
`timescale 1ns/1ps

module settings_checker (
    input logic                         CLK,
    input logic                         reset,
    input ctl_pkg::bus_word_t           host_dout,
    input logic                         silencer_update,
    input logic                         sync_update,
    input settings_pkg::silencer_flag_t silencer_flag,
    input settings_pkg::silencer_word_t update_rate_intensity,
    input settings_pkg::silencer_word_t update_rate_phase,
    input settings_pkg::silencer_word_t completion_steps_intensity,
    input settings_pkg::silencer_word_t completion_steps_phase,
    input settings_pkg::sync_time_t     ecat_sync_time,
    input logic                         force_fan
);
    silencer_pulse: assert property (@(posedge CLK) disable iff (reset)
        silencer_update |=> !silencer_update)
        else $error("silencer_update stayed high for more than one cycle");

    sync_pulse: assert property (@(posedge CLK) disable iff (reset)
        sync_update |=> !sync_update)
        else $error("sync_update stayed high for more than one cycle");

    updates_apart: assert property (@(posedge CLK) disable iff (reset)
        !(silencer_update && sync_update))
        else $error("silencer_update and sync_update high together");

    // Strobes are cleared from the second reset edge on.
    quiet_in_reset: assert property (@(posedge CLK)
        (reset && $past(reset)) |-> (!silencer_update && !sync_update))
        else $error("update strobe during reset");

    outputs_known: assert property (@(posedge CLK) disable iff (reset)
        !$isunknown({host_dout, silencer_flag, update_rate_intensity, update_rate_phase,
                     completion_steps_intensity, completion_steps_phase,
                     ecat_sync_time, force_fan, silencer_update, sync_update}))
        else $error("settings output unknown after reset");

endmodule

bind settings_top settings_checker u_settings_checker (.*);

/* dv/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic CLK,
    output logic reset
);
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Reset covers the first 16 rising edges.
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge CLK);
        reset <= 1'b0;
    end

endmodule

/* source/settings_top.sv */
`timescale 1ns/1ps

module settings_top (
    input  logic                         CLK,
    input  logic                         reset,
    input  logic                         host_we,
    input  ctl_pkg::bus_addr_t           host_addr,
    input  ctl_pkg::bus_word_t           host_din,
    output ctl_pkg::bus_word_t           host_dout,
    input  logic                         thermo,
    input  logic                         mod_segment,
    input  logic                         stm_segment,
    input  ctl_pkg::bus_word_t           stm_cycle,
    output settings_pkg::silencer_flag_t silencer_flag,
    output settings_pkg::silencer_word_t update_rate_intensity,
    output settings_pkg::silencer_word_t update_rate_phase,
    output settings_pkg::silencer_word_t completion_steps_intensity,
    output settings_pkg::silencer_word_t completion_steps_phase,
    output logic                         silencer_update,
    output settings_pkg::sync_time_t     ecat_sync_time,
    output logic                         sync_update,
    output logic                         force_fan
);
    import ctl_pkg::*;

    logic ctl_we;
    bus_addr_t ctl_addr;
    bus_word_t ctl_din;
    bus_word_t ctl_dout;

    bus_addr_t silencer_addr;
    bus_addr_t sync_addr;
    logic silencer_start;
    logic sync_start;
    logic silencer_done;
    logic sync_done;

    // Host on port A, controller on port B.
    cnt_ram u_cnt_ram (
        .CLK    (CLK),
        .a_we   (host_we),
        .a_addr (host_addr),
        .a_din  (host_din),
        .a_dout (host_dout),
        .b_we   (ctl_we),
        .b_addr (ctl_addr),
        .b_din  (ctl_din),
        .b_dout (ctl_dout)
    );

    ctl_poller u_ctl_poller (
        .CLK            (CLK),
        .reset          (reset),
        .thermo         (thermo),
        .mod_segment    (mod_segment),
        .stm_segment    (stm_segment),
        .stm_cycle      (stm_cycle),
        .rd_data        (ctl_dout),
        .silencer_addr  (silencer_addr),
        .sync_addr      (sync_addr),
        .silencer_done  (silencer_done),
        .sync_done      (sync_done),
        .silencer_start (silencer_start),
        .sync_start     (sync_start),
        .ctl_we         (ctl_we),
        .ctl_addr       (ctl_addr),
        .ctl_din        (ctl_din),
        .force_fan      (force_fan)
    );

    silencer_loader u_silencer_loader (
        .CLK                        (CLK),
        .reset                      (reset),
        .start                      (silencer_start),
        .rd_data                    (ctl_dout),
        .rd_addr                    (silencer_addr),
        .done                       (silencer_done),
        .silencer_flag              (silencer_flag),
        .update_rate_intensity      (update_rate_intensity),
        .update_rate_phase          (update_rate_phase),
        .completion_steps_intensity (completion_steps_intensity),
        .completion_steps_phase     (completion_steps_phase),
        .silencer_update            (silencer_update)
    );

    sync_loader u_sync_loader (
        .CLK            (CLK),
        .reset          (reset),
        .start          (sync_start),
        .rd_data        (ctl_dout),
        .rd_addr        (sync_addr),
        .done           (sync_done),
        .ecat_sync_time (ecat_sync_time),
        .sync_update    (sync_update)
    );

endmodule

/* source/sync_loader.sv */
`timescale 1ns/1ps

module sync_loader (
    input  logic                     CLK,
    input  logic                     reset,
    input  logic                     start,
    input  ctl_pkg::bus_word_t       rd_data,
    output ctl_pkg::bus_addr_t       rd_addr,
    output logic                     done,
    output settings_pkg::sync_time_t ecat_sync_time,
    output logic                     sync_update
);
    import ctl_pkg::*;
    import settings_pkg::*;

    logic issue_valid;
    sync_idx_t issue_idx;
    logic [RAM_READ_LATENCY-1:0] pipe_valid;
    sync_idx_t pipe_idx [RAM_READ_LATENCY];

    always_ff @(posedge CLK) begin
        if (reset) begin
            issue_valid <= 1'b0;
            issue_idx <= '0;
            rd_addr <= ADDR_SYNC_BASE;
        end else if (start) begin
            issue_valid <= 1'b1;
            issue_idx <= '0;
            rd_addr <= ADDR_SYNC_BASE;
        end else if (issue_valid) begin
            if (issue_idx == sync_idx_t'(SYNC_WORDS - 1)) begin
                issue_valid <= 1'b0;
            end else begin
                issue_idx <= issue_idx + 1'b1;
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[RAM_READ_LATENCY-2:0], issue_valid};
        end
    end

    always_ff @(posedge CLK) begin
        pipe_idx[0] <= issue_idx;
        for (int i = 1; i < RAM_READ_LATENCY; i++) begin
            pipe_idx[i] <= pipe_idx[i-1];
        end
    end

    // Word n fills slice n, low slice first.
    always_ff @(posedge CLK) begin
        if (reset) begin
            done <= 1'b0;
            ecat_sync_time <= SYNC_TIME_DEFAULT;
        end else begin
            done <= 1'b0;
            if (pipe_valid[RAM_READ_LATENCY-1]) begin
                ecat_sync_time[pipe_idx[RAM_READ_LATENCY-1]*BUS_DATA_WIDTH +: BUS_DATA_WIDTH]
                    <= rd_data;
                if (pipe_idx[RAM_READ_LATENCY-1] == sync_idx_t'(SYNC_WORDS - 1)) begin
                    done <= 1'b1;
                end
            end
        end
    end

    assign sync_update = done;

endmodule

/* source/silencer_loader.sv */
`timescale 1ns/1ps

module silencer_loader (
    input  logic                         CLK,
    input  logic                         reset,
    input  logic                         start,
    input  ctl_pkg::bus_word_t           rd_data,
    output ctl_pkg::bus_addr_t           rd_addr,
    output logic                         done,
    output settings_pkg::silencer_flag_t silencer_flag,
    output settings_pkg::silencer_word_t update_rate_intensity,
    output settings_pkg::silencer_word_t update_rate_phase,
    output settings_pkg::silencer_word_t completion_steps_intensity,
    output settings_pkg::silencer_word_t completion_steps_phase,
    output logic                         silencer_update
);
    import ctl_pkg::*;
    import settings_pkg::*;

    logic issue_valid;
    silencer_idx_t issue_idx;
    logic [RAM_READ_LATENCY-1:0] pipe_valid;
    silencer_idx_t pipe_idx [RAM_READ_LATENCY];

    // One address per cycle from the block base.
    always_ff @(posedge CLK) begin
        if (reset) begin
            issue_valid <= 1'b0;
            issue_idx <= '0;
            rd_addr <= ADDR_SILENCER_BASE;
        end else if (start) begin
            issue_valid <= 1'b1;
            issue_idx <= '0;
            rd_addr <= ADDR_SILENCER_BASE;
        end else if (issue_valid) begin
            if (issue_idx == silencer_idx_t'(SILENCER_WORDS - 1)) begin
                issue_valid <= 1'b0;
            end else begin
                issue_idx <= issue_idx + 1'b1;
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // Field index rides along with each read.
    always_ff @(posedge CLK) begin
        if (reset) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[RAM_READ_LATENCY-2:0], issue_valid};
        end
    end

    always_ff @(posedge CLK) begin
        pipe_idx[0] <= issue_idx;
        for (int i = 1; i < RAM_READ_LATENCY; i++) begin
            pipe_idx[i] <= pipe_idx[i-1];
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            done <= 1'b0;
            silencer_flag <= SILENCER_FLAG_DEFAULT;
            update_rate_intensity <= UPDATE_RATE_DEFAULT;
            update_rate_phase <= UPDATE_RATE_DEFAULT;
            completion_steps_intensity <= COMPLETION_STEPS_INTENSITY_DEFAULT;
            completion_steps_phase <= COMPLETION_STEPS_PHASE_DEFAULT;
        end else begin
            done <= 1'b0;
            if (pipe_valid[RAM_READ_LATENCY-1]) begin
                case (pipe_idx[RAM_READ_LATENCY-1])
                    0:       silencer_flag <= rd_data[SILENCER_FLAG_WIDTH-1:0];
                    1:       update_rate_intensity <= rd_data;
                    2:       update_rate_phase <= rd_data;
                    3:       completion_steps_intensity <= rd_data;
                    default: completion_steps_phase <= rd_data;
                endcase
                if (pipe_idx[RAM_READ_LATENCY-1] == silencer_idx_t'(SILENCER_WORDS - 1)) begin
                    done <= 1'b1;
                end
            end
        end
    end

    // Strobe lines up with the new field values.
    assign silencer_update = done;

endmodule

/* source/ctl_poller.sv */
`timescale 1ns/1ps

module ctl_poller (
    input  logic               CLK,
    input  logic               reset,
    input  logic               thermo,
    input  logic               mod_segment,
    input  logic               stm_segment,
    input  ctl_pkg::bus_word_t stm_cycle,
    input  ctl_pkg::bus_word_t rd_data,
    input  ctl_pkg::bus_addr_t silencer_addr,
    input  ctl_pkg::bus_addr_t sync_addr,
    input  logic               silencer_done,
    input  logic               sync_done,
    output logic               silencer_start,
    output logic               sync_start,
    output logic               ctl_we,
    output ctl_pkg::bus_addr_t ctl_addr,
    output ctl_pkg::bus_word_t ctl_din,
    output logic               force_fan
);
    import ctl_pkg::*;

    typedef enum logic [3:0] {
        ST_WR_VER_MAJOR,
        ST_WR_VER_MINOR,
        ST_WR_STATE,
        ST_RD_FLAGS,
        ST_WAIT_0,
        ST_WAIT_1,
        ST_CAPTURE,
        ST_DISPATCH,
        ST_LOAD_SILENCER,
        ST_LOAD_SYNC
    } state_t;

    state_t state;
    bus_word_t flags;
    bus_word_t state_word;
    bus_addr_t addr_q;

    always_comb begin
        state_word = '0;
        state_word[FPGA_STATE_BIT_THERMO] = thermo;
        state_word[FPGA_STATE_BIT_MOD_SEGMENT] = mod_segment;
        state_word[FPGA_STATE_BIT_STM_SEGMENT] = stm_segment;
        state_word[FPGA_STATE_BIT_STM_CYCLE_ZERO] = (stm_cycle == '0);
    end

    // A running loader owns the read address.
    always_comb begin
        case (state)
            ST_LOAD_SILENCER: ctl_addr = silencer_addr;
            ST_LOAD_SYNC:     ctl_addr = sync_addr;
            default:          ctl_addr = addr_q;
        endcase
    end

    assign force_fan = flags[CTL_FLAG_BIT_FORCE_FAN];

    always_ff @(posedge CLK) begin
        if (reset) begin
            state <= ST_WR_VER_MAJOR;
            flags <= '0;
            ctl_we <= 1'b0;
            addr_q <= ADDR_CTL_FLAG;
            silencer_start <= 1'b0;
            sync_start <= 1'b0;
        end else begin
            silencer_start <= 1'b0;
            sync_start <= 1'b0;
            case (state)
                ST_WR_VER_MAJOR: begin
                    ctl_we <= 1'b1;
                    addr_q <= ADDR_VERSION_NUM_MAJOR;
                    ctl_din <= {8'h00, VERSION_NUM_MAJOR};
                    state <= ST_WR_VER_MINOR;
                end
                ST_WR_VER_MINOR: begin
                    addr_q <= ADDR_VERSION_NUM_MINOR;
                    ctl_din <= {8'h00, VERSION_NUM_MINOR};
                    state <= ST_RD_FLAGS;
                end
                ST_WR_STATE: begin
                    ctl_we <= 1'b1;
                    addr_q <= ADDR_FPGA_STATE;
                    ctl_din <= state_word;
                    state <= ST_RD_FLAGS;
                end
                ST_RD_FLAGS: begin
                    ctl_we <= 1'b0;
                    addr_q <= ADDR_CTL_FLAG;
                    state <= ST_WAIT_0;
                end
                ST_WAIT_0: state <= ST_WAIT_1;
                ST_WAIT_1: state <= ST_CAPTURE;
                ST_CAPTURE: begin
                    flags <= rd_data;
                    state <= ST_DISPATCH;
                end
                // Silencer first, sync on a later pass.
                ST_DISPATCH: begin
                    if (flags[CTL_FLAG_BIT_SILENCER_SET]) begin
                        flags[CTL_FLAG_BIT_SILENCER_SET] <= 1'b0;
                        silencer_start <= 1'b1;
                        state <= ST_LOAD_SILENCER;
                    end else if (flags[CTL_FLAG_BIT_SYNC_SET]) begin
                        flags[CTL_FLAG_BIT_SYNC_SET] <= 1'b0;
                        sync_start <= 1'b1;
                        state <= ST_LOAD_SYNC;
                    end else begin
                        state <= ST_WR_STATE;
                    end
                end
                ST_LOAD_SILENCER, ST_LOAD_SYNC: begin
                    if ((state == ST_LOAD_SILENCER && silencer_done) ||
                        (state == ST_LOAD_SYNC && sync_done)) begin
                        // Write back the cleared flags.
                        ctl_we <= 1'b1;
                        addr_q <= ADDR_CTL_FLAG;
                        ctl_din <= flags;
                        state <= ST_WR_STATE;
                    end
                end
                default: state <= ST_WR_STATE;
            endcase
        end
    end

endmodule

/* source/cnt_ram.sv */
`timescale 1ns/1ps

module cnt_ram (
    input  logic               CLK,

    input  logic               a_we,
    input  ctl_pkg::bus_addr_t a_addr,
    input  ctl_pkg::bus_word_t a_din,
    output ctl_pkg::bus_word_t a_dout,

    input  logic               b_we,
    input  ctl_pkg::bus_addr_t b_addr,
    input  ctl_pkg::bus_word_t b_din,
    output ctl_pkg::bus_word_t b_dout
);
    import ctl_pkg::*;

    // Power-up contents are zero, as in block RAM.
    bus_word_t mem [RAM_DEPTH] = '{default: '0};

    bus_word_t a_rd_q;
    bus_word_t b_rd_q;

    // Port B is written last, so it wins a same-address collision.
    always_ff @(posedge CLK) begin
        if (a_we) begin
            mem[a_addr] <= a_din;
        end
        if (b_we) begin
            mem[b_addr] <= b_din;
        end
    end

    // Array read plus one output stage.
    always_ff @(posedge CLK) begin
        a_rd_q <= mem[a_addr];
        b_rd_q <= mem[b_addr];
        a_dout <= a_rd_q;
        b_dout <= b_rd_q;
    end

endmodule

/* source/settings_pkg.sv */
package settings_pkg;

    // Register block sizes.
    localparam int SILENCER_WORDS = 5;
    localparam int SYNC_WORDS = 4;

    localparam int SILENCER_FLAG_WIDTH = 8;
    localparam int SILENCER_WORD_WIDTH = 16;
    localparam int SYNC_TIME_WIDTH = 64;

    typedef logic [SILENCER_FLAG_WIDTH-1:0] silencer_flag_t;
    typedef logic [SILENCER_WORD_WIDTH-1:0] silencer_word_t;
    typedef logic [SYNC_TIME_WIDTH-1:0] sync_time_t;

    // Word index inside a block.
    typedef logic [$clog2(SILENCER_WORDS)-1:0] silencer_idx_t;
    typedef logic [$clog2(SYNC_WORDS)-1:0] sync_idx_t;

    // Values held until the host loads a block.
    localparam silencer_flag_t SILENCER_FLAG_DEFAULT = 8'd0;
    localparam silencer_word_t UPDATE_RATE_DEFAULT = 16'd256;
    localparam silencer_word_t COMPLETION_STEPS_INTENSITY_DEFAULT = 16'd10;
    localparam silencer_word_t COMPLETION_STEPS_PHASE_DEFAULT = 16'd40;
    localparam sync_time_t SYNC_TIME_DEFAULT = 64'd0;

endpackage

/* source/ctl_pkg.sv */
package ctl_pkg;

    // Bus geometry.
    localparam int BUS_ADDR_WIDTH = 8;
    localparam int BUS_DATA_WIDTH = 16;
    localparam int RAM_DEPTH = 2 ** BUS_ADDR_WIDTH;
    localparam int RAM_READ_LATENCY = 2;

    typedef logic [BUS_ADDR_WIDTH-1:0] bus_addr_t;
    typedef logic [BUS_DATA_WIDTH-1:0] bus_word_t;

    // Control and status words.
    localparam bus_addr_t ADDR_CTL_FLAG = 8'h00;
    localparam bus_addr_t ADDR_FPGA_STATE = 8'h01;
    localparam bus_addr_t ADDR_VERSION_NUM_MAJOR = 8'h02;
    localparam bus_addr_t ADDR_VERSION_NUM_MINOR = 8'h03;

    // Flag, rate intensity, rate phase, steps intensity, steps phase.
    localparam bus_addr_t ADDR_SILENCER_BASE = 8'h40;

    // Four words, least significant first.
    localparam bus_addr_t ADDR_SYNC_BASE = 8'h50;

    // Bits of the control flags word.
    localparam int CTL_FLAG_BIT_SILENCER_SET = 2;
    localparam int CTL_FLAG_BIT_SYNC_SET = 4;
    localparam int CTL_FLAG_BIT_FORCE_FAN = 13;

    // Bits of the FPGA state word, the rest read as zero.
    localparam int FPGA_STATE_BIT_THERMO = 0;
    localparam int FPGA_STATE_BIT_MOD_SEGMENT = 1;
    localparam int FPGA_STATE_BIT_STM_SEGMENT = 2;
    localparam int FPGA_STATE_BIT_STM_CYCLE_ZERO = 3;

    localparam logic [7:0] VERSION_NUM_MAJOR = 8'hA2;
    localparam logic [7:0] VERSION_NUM_MINOR = 8'h01;

endpackage
